// File: logic/usb_tx_pkg.sv
// USB full-speed transmit package
// PID codes, line levels, buffer sizing, CRC16 constants and the bit and pad structs

package usb_tx_pkg;

  // Clocks per 12 MHz bit at 48 MHz
  localparam int unsigned BitDiv = 4;

  // Transmit buffer sizing
  localparam int unsigned TxBufDepth = 64;
  localparam int unsigned BufAddrW   = 6;

  // SYNC byte, shifted out LSB first
  localparam logic [7:0] SyncPattern = 8'h80;

  // CRC16 preset and polynomial
  localparam logic [15:0] Crc16Init = 16'hFFFF;
  localparam logic [15:0] Crc16Poly = 16'h8005;

  // PIDs whose two low bits are 2'b11 carry data
  typedef enum logic [3:0] {
    PidOut   = 4'b0001,
    PidIn    = 4'b1001,
    PidSetup = 4'b1101,
    PidData0 = 4'b0011,
    PidData1 = 4'b1011,
    PidAck   = 4'b0010,
    PidNak   = 4'b1010
  } pid_e;

  // One serial bit slot from the serializer
  typedef struct packed {
    logic data;
    logic oe;
    logic se0;
  } tx_bit_t;

  // Pad outputs
  typedef struct packed {
    logic oe;
    logic d;
    logic se0;
    logic dp;
    logic dn;
  } usb_line_t;

  // Line states, J is the idle level
  localparam logic      LineJ    = 1'b1;
  localparam usb_line_t LineIdle = '{oe: 1'b0, d: LineJ, se0: 1'b0, dp: 1'b1, dn: 1'b0};

endpackage

// File: logic/usb_bit_strobe_gen.sv
// Bit strobe generator
// Divides the 48 MHz clock into a one-cycle 12 MHz bit strobe

module usb_bit_strobe_gen (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic link_reset_i,
  output logic bit_strobe_o
);

  logic [1:0] cnt_q, cnt_d;

  // Strobe on the last count before wrap
  assign bit_strobe_o = (cnt_q == 2'(usb_tx_pkg::BitDiv - 1));
  assign cnt_d        = bit_strobe_o ? 2'd0 : cnt_q + 2'd1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= 2'd0;
    end else if (link_reset_i) begin
      // Restart so bits stay aligned after link reset
      cnt_q <= 2'd0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

// File: logic/usb_tx_buffer.sv
// Transmit byte FIFO
// Written from the software side, drained by the serializer through avail/get

module usb_tx_buffer (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       link_reset_i,
  input  logic       wr_i,
  input  logic [7:0] wr_data_i,
  output logic       full_o,
  output logic       avail_o,
  input  logic       get_i,
  output logic [7:0] rd_data_o
);

  localparam int unsigned AW = usb_tx_pkg::BufAddrW;

  logic [7:0]    mem_q [usb_tx_pkg::TxBufDepth];
  logic [AW-1:0] wr_ptr_q, rd_ptr_q;
  logic [AW:0]   count_q;
  logic          push, pop;

  assign full_o    = (count_q == (AW+1)'(usb_tx_pkg::TxBufDepth));
  assign avail_o   = (count_q != '0);
  assign rd_data_o = mem_q[rd_ptr_q];

  // Writes while full are dropped
  assign push = wr_i && !full_o;
  assign pop  = get_i && avail_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  ////////////////////
  // Pointers and fill count
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (link_reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: logic/usb_fs_serializer.sv
// USB full-speed packet serializer
// Frames SYNC, PID, payload and CRC16, bit-stuffs them and emits one bit slot per strobe

module usb_fs_serializer (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                link_reset_i,
  input  logic                bit_strobe_i,
  input  logic                pkt_start_i,
  input  logic                tx_osc_test_mode_i,
  input  logic                data_avail_i,
  input  logic [3:0]          pid_i,
  input  logic [7:0]          data_i,
  output logic                data_get_o,
  output logic                start_o,
  output logic                test_start_o,
  output usb_tx_pkg::tx_bit_t tx_bit_o
);

  typedef enum logic [2:0] {Idle, Sync, Pid, DataOrCrcHi, CrcLo, Eop, OscTest} state_e;

  state_e           state_q, state_d;
  usb_tx_pkg::pid_e pid_q;
  logic [7:0]       data_sr_q, data_sr_d;
  logic [7:0]       oe_sr_q, oe_sr_d;
  logic [7:0]       se0_sr_q, se0_sr_d;
  logic [4:0]       hist_q, hist_d;
  logic [2:0]       cnt_q, cnt_d;
  logic [15:0]      crc_q, crc_d;
  logic [15:0]      crc_tx;
  logic [5:0]       bit_history;
  logic             payload_q, payload_d;
  logic             byte_strobe_q, byte_strobe_d;
  logic             stuffed_q;
  logic             bitstuff;
  logic             line_free;

  assign tx_bit_o = '{data: data_sr_q[0], oe: oe_sr_q[0], se0: se0_sr_q[0]};

  // Six ones in a row force a stuffed zero into the next slot
  assign bit_history = {data_sr_q[0], hist_q};
  assign bitstuff    = &bit_history;

  // A new packet waits until the previous end-of-packet has drained
  assign line_free = ~|oe_sr_q;

  // Inverted and bit reversed, so the high half starts with crc_q[15]
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      crc_tx[i] = ~crc_q[15-i];
    end
  end

  ////////////////////
  // Framing FSM
  ////////////////////
  always_comb begin
    state_d      = state_q;
    data_sr_d    = data_sr_q;
    oe_sr_d      = oe_sr_q;
    se0_sr_d     = se0_sr_q;
    payload_d    = payload_q;
    hist_d       = hist_q;
    cnt_d        = cnt_q;
    start_o      = 1'b0;
    test_start_o = 1'b0;
    data_get_o   = 1'b0;

    unique case (state_q)
      Idle: begin
        if (line_free && tx_osc_test_mode_i) begin
          state_d      = OscTest;
          test_start_o = 1'b1;
        end else if (line_free && pkt_start_i) begin
          state_d = Sync;
          start_o = 1'b1;
        end
      end
      Sync: begin
        if (byte_strobe_q) begin
          state_d   = Pid;
          data_sr_d = usb_tx_pkg::SyncPattern;
          oe_sr_d   = 8'hFF;
          se0_sr_d  = 8'h00;
        end
      end
      Pid: begin
        if (byte_strobe_q) begin
          state_d   = (pid_q[1:0] == 2'b11) ? DataOrCrcHi : Eop;
          data_sr_d = {~pid_q, pid_q};
          oe_sr_d   = 8'hFF;
          se0_sr_d  = 8'h00;
        end
      end
      DataOrCrcHi: begin
        if (byte_strobe_q) begin
          oe_sr_d  = 8'hFF;
          se0_sr_d = 8'h00;
          if (data_avail_i) begin
            payload_d  = 1'b1;
            data_get_o = 1'b1;
            data_sr_d  = data_i;
          end else begin
            // Buffer ran dry at a byte boundary, close with the CRC
            state_d   = CrcLo;
            payload_d = 1'b0;
            data_sr_d = crc_tx[7:0];
          end
        end
      end
      CrcLo: begin
        if (byte_strobe_q) begin
          state_d   = Eop;
          data_sr_d = crc_tx[15:8];
          oe_sr_d   = 8'hFF;
          se0_sr_d  = 8'h00;
        end
      end
      Eop: begin
        if (byte_strobe_q) begin
          // SE0, SE0, J then release the bus
          state_d   = Idle;
          data_sr_d = 8'h00;
          oe_sr_d   = 8'h07;
          se0_sr_d  = 8'h07;
        end
      end
      OscTest: begin
        if (byte_strobe_q) begin
          data_sr_d = 8'h00;
          se0_sr_d  = 8'h00;
          if (tx_osc_test_mode_i) begin
            oe_sr_d = 8'hFF;
          end else begin
            oe_sr_d = 8'h00;
            state_d = Idle;
          end
        end
      end
      default: state_d = Idle;
    endcase

    // Shifting and stuffing, one bit time of gap before SYNC
    if (start_o) begin
      cnt_d  = 3'd7;
      hist_d = '0;
    end else if (bit_strobe_i) begin
      hist_d = bit_history[5:1];
      if (bitstuff) begin
        data_sr_d[0] = 1'b0;
      end else begin
        cnt_d     = cnt_q + 3'd1;
        data_sr_d = data_sr_q >> 1;
        oe_sr_d   = oe_sr_q >> 1;
        se0_sr_d  = se0_sr_q >> 1;
      end
    end
  end

  assign byte_strobe_d = bit_strobe_i && !bitstuff && !start_o && (cnt_q == 3'd0);

  // CRC16 over payload bits, stuffed zeros excluded
  always_comb begin
    crc_d = crc_q;
    if (start_o) begin
      crc_d = usb_tx_pkg::Crc16Init;
    end else if (bit_strobe_i && payload_q && !stuffed_q) begin
      crc_d = {crc_q[14:0], 1'b0} ^
              ({16{data_sr_q[0] ^ crc_q[15]}} & usb_tx_pkg::Crc16Poly);
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_o) begin
      pid_q <= usb_tx_pkg::pid_e'(pid_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= Idle;
      data_sr_q     <= '0;
      oe_sr_q       <= '0;
      se0_sr_q      <= '0;
      hist_q        <= '0;
      cnt_q         <= '0;
      crc_q         <= '0;
      payload_q     <= 1'b0;
      byte_strobe_q <= 1'b0;
      stuffed_q     <= 1'b0;
    end else if (link_reset_i) begin
      state_q       <= Idle;
      data_sr_q     <= '0;
      oe_sr_q       <= '0;
      se0_sr_q      <= '0;
      hist_q        <= '0;
      cnt_q         <= '0;
      crc_q         <= '0;
      payload_q     <= 1'b0;
      byte_strobe_q <= 1'b0;
      stuffed_q     <= 1'b0;
    end else begin
      state_q       <= state_d;
      data_sr_q     <= data_sr_d;
      oe_sr_q       <= oe_sr_d;
      se0_sr_q      <= se0_sr_d;
      hist_q        <= hist_d;
      cnt_q         <= cnt_d;
      crc_q         <= crc_d;
      payload_q     <= payload_d;
      byte_strobe_q <= byte_strobe_d;
      // Marks that the slot now on the line is a stuffed zero
      if (bit_strobe_i) begin
        stuffed_q <= bitstuff;
      end
    end
  end

endmodule

// File: logic/usb_line_driver.sv
// USB line driver
// NRZI encoding, end-of-packet sequencing, D+/D- flip and registered pads

module usb_line_driver (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  link_reset_i,
  input  logic                  bit_strobe_i,
  input  logic                  cfg_pinflip_i,
  input  logic                  start_i,
  input  logic                  test_start_i,
  input  usb_tx_pkg::tx_bit_t   tx_bit_i,
  output logic                  pkt_end_o,
  output usb_tx_pkg::usb_line_t line_o
);

  typedef enum logic [1:0] {OsIdle, OsWaitByte, OsTransmit} out_state_e;

  // Count value of the final J slot
  localparam logic [1:0] EopJSlot = 2'd2;

  out_state_e            out_state_q, out_state_d;
  usb_tx_pkg::usb_line_t line_q, line_d;
  logic [1:0]            eop_cnt_q, eop_cnt_d;
  logic                  pkt_end_q, pkt_end_d;
  logic                  nrzi_en;
  logic                  oe_n, d_n, se0_n;

  assign line_o    = line_q;
  assign pkt_end_o = pkt_end_q;

  // First slot with oe high opens the transmission
  always_comb begin
    out_state_d = out_state_q;
    nrzi_en     = 1'b0;
    unique case (out_state_q)
      OsIdle: begin
        if (start_i || test_start_i) begin
          out_state_d = OsWaitByte;
        end
      end
      OsWaitByte: begin
        nrzi_en = tx_bit_i.oe;
        if (bit_strobe_i && tx_bit_i.oe) begin
          out_state_d = OsTransmit;
        end
      end
      OsTransmit: begin
        nrzi_en = 1'b1;
        if (bit_strobe_i && !tx_bit_i.oe) begin
          out_state_d = OsIdle;
        end
      end
      default: out_state_d = OsIdle;
    endcase
  end

  ////////////////////
  // NRZI and EOP
  ////////////////////
  always_comb begin
    oe_n      = line_q.oe;
    d_n       = line_q.d;
    se0_n     = line_q.se0;
    eop_cnt_d = eop_cnt_q;
    pkt_end_d = 1'b0;

    if (start_i || test_start_i) begin
      // First zero of the stream then lands on K
      d_n       = usb_tx_pkg::LineJ;
      eop_cnt_d = 2'd0;
    end else if (bit_strobe_i && nrzi_en) begin
      oe_n = tx_bit_i.oe;
      if (tx_bit_i.se0) begin
        eop_cnt_d = eop_cnt_q + 2'd1;
        if (eop_cnt_q == EopJSlot) begin
          d_n       = usb_tx_pkg::LineJ;
          se0_n     = 1'b0;
          pkt_end_d = 1'b1;
        end else begin
          se0_n = 1'b1;
        end
      end else if (!tx_bit_i.data) begin
        d_n = ~line_q.d;
      end
      // Park at J once the bus is released
      if (!tx_bit_i.oe) begin
        d_n   = usb_tx_pkg::LineJ;
        se0_n = 1'b0;
      end
    end

    if (link_reset_i) begin
      oe_n      = 1'b0;
      d_n       = usb_tx_pkg::LineJ;
      se0_n     = 1'b0;
      pkt_end_d = 1'b0;
    end

    line_d.oe  = oe_n;
    line_d.d   = d_n;
    line_d.se0 = se0_n;
    line_d.dp  = (cfg_pinflip_i ? ~d_n :  d_n) & ~se0_n;
    line_d.dn  = (cfg_pinflip_i ?  d_n : ~d_n) & ~se0_n;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_state_q <= OsIdle;
      eop_cnt_q   <= 2'd0;
      pkt_end_q   <= 1'b0;
      line_q      <= usb_tx_pkg::LineIdle;
    end else begin
      out_state_q <= link_reset_i ? OsIdle : out_state_d;
      eop_cnt_q   <= link_reset_i ? 2'd0 : eop_cnt_d;
      pkt_end_q   <= pkt_end_d;
      line_q      <= line_d;
    end
  end

endmodule

// File: logic/usb_fs_tx_top.sv
// USB full-speed transmit top level
// Strobe generator, transmit buffer, serializer and line driver

module usb_fs_tx_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  link_reset_i,
  input  logic                  cfg_pinflip_i,
  input  logic                  tx_osc_test_mode_i,
  input  logic                  buf_wr_i,
  input  logic [7:0]            buf_wr_data_i,
  output logic                  buf_full_o,
  input  logic                  pkt_start_i,
  input  logic [3:0]            pid_i,
  output logic                  pkt_end_o,
  output usb_tx_pkg::usb_line_t line_o
);

  logic                bit_strobe;
  logic                data_avail;
  logic                data_get;
  logic [7:0]          rd_data;
  logic                pkt_start_seen;
  logic                test_start;
  usb_tx_pkg::tx_bit_t tx_bit;

  usb_bit_strobe_gen u_strobe (
    .clk_i,
    .rst_ni,
    .link_reset_i,
    .bit_strobe_o (bit_strobe)
  );

  usb_tx_buffer u_buffer (
    .clk_i,
    .rst_ni,
    .link_reset_i,
    .wr_i      (buf_wr_i),
    .wr_data_i (buf_wr_data_i),
    .full_o    (buf_full_o),
    .avail_o   (data_avail),
    .get_i     (data_get),
    .rd_data_o (rd_data)
  );

  usb_fs_serializer u_serializer (
    .clk_i,
    .rst_ni,
    .link_reset_i,
    .bit_strobe_i       (bit_strobe),
    .pkt_start_i,
    .tx_osc_test_mode_i,
    .data_avail_i       (data_avail),
    .pid_i,
    .data_i             (rd_data),
    .data_get_o         (data_get),
    .start_o            (pkt_start_seen),
    .test_start_o       (test_start),
    .tx_bit_o           (tx_bit)
  );

  usb_line_driver u_line (
    .clk_i,
    .rst_ni,
    .link_reset_i,
    .bit_strobe_i  (bit_strobe),
    .cfg_pinflip_i,
    .start_i       (pkt_start_seen),
    .test_start_i  (test_start),
    .tx_bit_i      (tx_bit),
    .pkt_end_o,
    .line_o
  );

endmodule

// File: tb/usb_fs_tx_properties.sv
// Pad output properties of the transmit top level
// Line legality, SE0 only while driving, idle at J and quiet in reset

module usb_fs_tx_properties (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  cfg_pinflip_i,
  input usb_tx_pkg::usb_line_t line_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Number of property failures so far
  int unsigned fail_cnt = 0;

  never_both_high: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(line_o.dp && line_o.dn))
    else begin
      $error("dp and dn both high");
      fail_cnt++;
    end

  se0_needs_oe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    line_o.se0 |-> line_o.oe)
    else begin
      $error("se0 without oe");
      fail_cnt++;
    end

  // Flip setting is registered, so compare with the previous sample
  idle_is_j: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !line_o.oe |-> (line_o.dp != line_o.dn) && (line_o.dp == !$past(cfg_pinflip_i)))
    else begin
      $error("undriven line is not at J");
      fail_cnt++;
    end

  quiet_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !line_o.oe)
    else begin
      $error("oe high during reset");
      fail_cnt++;
    end

endmodule

bind usb_fs_tx_top usb_fs_tx_properties u_props (
  .clk_i,
  .rst_ni,
  .cfg_pinflip_i,
  .line_o
);

// File: tb/usb_fs_tx_tb.sv
// USB full-speed transmit testbench
// Table-driven packets decoded from the pads, with reference CRC16, LFSR payloads and watchdog

module usb_fs_tx_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumTests    = 11;
  localparam int KindLfsr    = 0;
  localparam int KindOnes    = 1;
  localparam int KindPattern = 2;
  localparam int BitNs       = 32;

  typedef logic [7:0] byte_q_t[$];

  typedef struct {
    usb_tx_pkg::pid_e pid;
    int               len;
    int               kind;
    logic             flip;
    logic             link_rst;
  } entry_t;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  link_reset_i;
  logic                  cfg_pinflip_i;
  logic                  tx_osc_test_mode_i;
  logic                  buf_wr_i;
  logic [7:0]            buf_wr_data_i;
  logic                  buf_full_o;
  logic                  pkt_start_i;
  logic [3:0]            pid_i;
  logic                  pkt_end_o;
  usb_tx_pkg::usb_line_t line_o;

  entry_t      table_q [NumTests];
  byte_q_t     exp_q;
  byte_q_t     got_q;
  logic [31:0] lfsr_q;
  logic [1:0]  phase_q;
  int          end_cnt;
  int          errors;
  int          test_err;
  longint      limit_ns;

  usb_fs_tx_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Own bit-time reference, line is stable at phase 2
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni || link_reset_i) begin
      phase_q <= 2'd0;
    end else begin
      phase_q <= phase_q + 2'd1;
    end
  end

  always @(posedge clk_i) begin
    if (pkt_end_o) begin
      end_cnt++;
    end
  end

  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("Timeout, the run did not finish within %0d ns", limit_ns);
    $display(">>> FAIL");
    $finish;
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      b[i]   = lfsr_q[0];
    end
  endtask

  // Preset all ones, LSB first, then inverted and bit reversed
  function automatic logic [15:0] crc16_ref(input byte_q_t bytes);
    logic [15:0] crc;
    logic [15:0] res;
    logic        fb;
    crc = 16'hFFFF;
    foreach (bytes[k]) begin
      for (int i = 0; i < 8; i++) begin
        fb  = bytes[k][i] ^ crc[15];
        crc = {crc[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
      end
    end
    for (int i = 0; i < 16; i++) begin
      res[i] = ~crc[15-i];
    end
    return res;
  endfunction

  function automatic logic is_j(input logic flip);
    return flip ? (!line_o.dp && line_o.dn) : (line_o.dp && !line_o.dn);
  endfunction

  task automatic wait_bit();
    do @(negedge clk_i); while (phase_q != 2'd2);
  endtask

  task automatic fail_msg(input string msg);
    $display("%s", msg);
    test_err++;
  endtask

  task automatic check_eop(input logic flip);
    wait_bit();
    assert (line_o.se0 && line_o.oe) else fail_msg("Bad end-of-packet shape, second SE0 missing");
    wait_bit();
    assert (!line_o.se0 && line_o.oe && is_j(flip))
      else fail_msg("Bad end-of-packet shape, final J missing");
    wait_bit();
    assert (!line_o.oe && is_j(flip))
      else fail_msg("Bad end-of-packet shape, bus not released at J");
  endtask

  // NRZI decode with destuffing until SE0
  task automatic receive_packet(input logic flip, input int max_bits, output int stuffed);
    logic       prev;
    logic       lvl;
    logic       b;
    logic [7:0] sh;
    int         ones;
    int         nbits;
    int         guard;
    bit         done;
    got_q.delete();
    stuffed = 0;
    prev    = 1'b1;
    ones    = 0;
    nbits   = 0;
    guard   = 0;
    sh      = '0;
    do begin
      wait_bit();
      guard++;
    end while (!line_o.oe && guard < 64);
    if (!line_o.oe) begin
      fail_msg("No packet appeared on the line within 64 bit times");
      return;
    end
    done  = 1'b0;
    guard = 0;
    while (!done) begin
      if (line_o.se0) begin
        check_eop(flip);
        done = 1'b1;
      end else begin
        lvl  = flip ? line_o.dn : line_o.dp;
        b    = (lvl == prev);
        prev = lvl;
        if (ones == 6) begin
          assert (!b) else fail_msg("Missing stuffed zero after six ones");
          stuffed++;
          ones = 0;
        end else begin
          ones = b ? ones + 1 : 0;
          sh   = {b, sh[7:1]};
          nbits++;
          if (nbits % 8 == 0) begin
            got_q.push_back(sh);
          end
        end
        wait_bit();
        guard++;
        if (guard > max_bits) begin
          fail_msg("No end-of-packet seen on the line");
          done = 1'b1;
        end
      end
    end
    assert (nbits % 8 == 0) else fail_msg("Packet is not a whole number of bytes");
  endtask

  task automatic write_byte(input logic [7:0] b);
    @(negedge clk_i);
    buf_wr_i      = 1'b1;
    buf_wr_data_i = b;
    @(negedge clk_i);
    buf_wr_i = 1'b0;
  endtask

  task automatic set_entry(input int idx, input usb_tx_pkg::pid_e pid, input int len,
                           input int kind, input logic flip, input logic lrst);
    table_q[idx] = '{pid: pid, len: len, kind: kind, flip: flip, link_rst: lrst};
  endtask

  task automatic run_entry(input int idx);
    entry_t     e;
    byte_q_t    pay;
    logic [7:0] b;
    logic [15:0] crc;
    int         stuffed;
    int         guard;
    e = table_q[idx];
    @(negedge clk_i);
    cfg_pinflip_i = e.flip;
    repeat (2) @(negedge clk_i);
    assert (!line_o.oe && line_o.d && is_j(e.flip))
      else fail_msg("Idle line is not parked at J");
    for (int i = 0; i < e.len; i++) begin
      if (e.kind == KindOnes) begin
        b = 8'hFF;
      end else if (e.kind == KindPattern) begin
        b = 8'(i * 37 + 8'h3C);
      end else begin
        rand_byte(b);
      end
      pay.push_back(b);
      write_byte(b);
    end
    exp_q.delete();
    exp_q.push_back(8'h80);
    exp_q.push_back({~e.pid, e.pid});
    if (e.pid[1:0] == 2'b11) begin
      crc = crc16_ref(pay);
      foreach (pay[k]) begin
        exp_q.push_back(pay[k]);
      end
      exp_q.push_back(crc[7:0]);
      exp_q.push_back(crc[15:8]);
    end
    end_cnt = 0;
    @(negedge clk_i);
    pkt_start_i = 1'b1;
    pid_i       = e.pid;
    @(negedge clk_i);
    pkt_start_i = 1'b0;
    if (e.link_rst) begin
      guard = 0;
      do begin
        wait_bit();
        guard++;
      end while (!line_o.oe && guard < 64);
      repeat (24) wait_bit();
      // Top the buffer up again so the flush is visible on buf_full_o
      guard = 0;
      while (!buf_full_o && guard < 16) begin
        write_byte(8'h5A);
        guard++;
      end
      assert (buf_full_o) else fail_msg("Buffer did not report full before link reset");
      assert (line_o.oe) else fail_msg("No packet in progress before link reset");
      @(negedge clk_i);
      link_reset_i = 1'b1;
      @(negedge clk_i);
      link_reset_i = 1'b0;
      assert (!line_o.oe && is_j(e.flip)) else fail_msg("Line not parked at J after link reset");
      assert (!buf_full_o)
        else $display("Error buf_full_o exp 0x0 got 0x%0h", buf_full_o);
      if (buf_full_o) test_err++;
      for (int i = 0; i < 16; i++) begin
        wait_bit();
        assert (!line_o.oe && is_j(e.flip))
          else fail_msg("Line left the parked J state after link reset");
      end
      return;
    end
    receive_packet(e.flip, (e.len + 6) * 12 + 40, stuffed);
    assert (got_q.size() == exp_q.size())
      else $display("Error byte count exp 0x%0h got 0x%0h", exp_q.size(), got_q.size());
    if (got_q.size() != exp_q.size()) test_err++;
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      assert (got_q[i] == exp_q[i])
        else $display("Error byte %0d exp 0x%02h got 0x%02h", i, exp_q[i], got_q[i]);
      if (got_q[i] != exp_q[i]) test_err++;
    end
    if (e.kind == KindOnes) begin
      assert (stuffed > 0) else fail_msg("No stuffed zeros seen in an all-ones payload");
    end
    assert (end_cnt == 1) else fail_msg("End-of-packet pulse count is not one");
  endtask

  ////////////////////
  // Oscillator test
  ////////////////////
  task automatic run_osc_test();
    logic prev;
    int   guard;
    @(negedge clk_i);
    cfg_pinflip_i      = 1'b0;
    tx_osc_test_mode_i = 1'b1;
    guard = 0;
    do begin
      wait_bit();
      guard++;
    end while (!line_o.oe && guard < 64);
    prev = line_o.dp;
    for (int i = 0; i < 16; i++) begin
      wait_bit();
      assert (line_o.oe && line_o.dp != prev && line_o.dp != line_o.dn)
        else fail_msg("Line did not toggle J/K in oscillator test");
      prev = line_o.dp;
    end
    @(negedge clk_i);
    tx_osc_test_mode_i = 1'b0;
    guard = 0;
    do begin
      wait_bit();
      guard++;
    end while (line_o.oe && guard < 12);
    assert (!line_o.oe && is_j(1'b0))
      else fail_msg("Bus not released at J after oscillator test");
  endtask

  initial begin
    int total;
    rst_ni             = 1'b0;
    link_reset_i       = 1'b0;
    cfg_pinflip_i      = 1'b0;
    tx_osc_test_mode_i = 1'b0;
    buf_wr_i           = 1'b0;
    buf_wr_data_i      = 8'h00;
    pkt_start_i        = 1'b0;
    pid_i              = 4'h0;
    lfsr_q             = 32'he5b9_bfbf;
    errors             = 0;
    end_cnt            = 0;
    limit_ns           = 0;

    set_entry(0,  usb_tx_pkg::PidOut,   0,  KindLfsr,    1'b0, 1'b0);
    set_entry(1,  usb_tx_pkg::PidIn,    0,  KindLfsr,    1'b0, 1'b0);
    set_entry(2,  usb_tx_pkg::PidSetup, 0,  KindLfsr,    1'b0, 1'b0);
    set_entry(3,  usb_tx_pkg::PidAck,   0,  KindLfsr,    1'b0, 1'b0);
    set_entry(4,  usb_tx_pkg::PidData0, 0,  KindLfsr,    1'b0, 1'b0);
    set_entry(5,  usb_tx_pkg::PidData1, 1,  KindLfsr,    1'b0, 1'b0);
    set_entry(6,  usb_tx_pkg::PidData0, 20, KindLfsr,    1'b0, 1'b0);
    set_entry(7,  usb_tx_pkg::PidData1, 8,  KindOnes,    1'b0, 1'b0);
    set_entry(8,  usb_tx_pkg::PidData0, 6,  KindPattern, 1'b1, 1'b0);
    set_entry(9,  usb_tx_pkg::PidData1, 64, KindLfsr,    1'b0, 1'b1);
    set_entry(10, usb_tx_pkg::PidData0, 5,  KindLfsr,    1'b0, 1'b0);

    total = 0;
    foreach (table_q[i]) total += table_q[i].len;
    limit_ns = longint'(total * 40 + (NumTests + 1) * 100 + 400) * BitNs;

    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;

    for (int t = 0; t < NumTests; t++) begin
      test_err = 0;
      run_entry(t);
      $display("Test %0d pid 0x%0h len %0d: %s", t, table_q[t].pid, table_q[t].len,
               (test_err == 0) ? "ok" : "errors");
      errors += test_err;
    end
    test_err = 0;
    run_osc_test();
    $display("Test %0d oscillator mode: %s", NumTests, (test_err == 0) ? "ok" : "errors");
    errors += test_err;

    // Concurrent pad properties bound into the DUT
    if (dut_i.u_props.fail_cnt != 0) begin
      $display("Pad properties failed %0d times", dut_i.u_props.fail_cnt);
      errors += int'(dut_i.u_props.fail_cnt);
    end

    $display("Tests run %0d, errors %0d", NumTests + 1, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: filelist.f
logic/usb_tx_pkg.sv
logic/usb_bit_strobe_gen.sv
logic/usb_tx_buffer.sv
logic/usb_fs_serializer.sv
logic/usb_line_driver.sv
logic/usb_fs_tx_top.sv
tb/usb_fs_tx_properties.sv
tb/usb_fs_tx_tb.sv

// File: Bender.yml
package:
  name: usb_fs_tx

sources:
  - files:
      - logic/usb_tx_pkg.sv
      - logic/usb_bit_strobe_gen.sv
      - logic/usb_tx_buffer.sv
      - logic/usb_fs_serializer.sv
      - logic/usb_line_driver.sv
      - logic/usb_fs_tx_top.sv
  - target: test
    files:
      - tb/usb_fs_tx_properties.sv
      - tb/usb_fs_tx_tb.sv
